// File: src/mc2_consts.svh
// platform base constants

`ifndef MC2_CONSTS_SVH
`define MC2_CONSTS_SVH

// SPI command codes from the I/O controller
`define MC2_CMD_STATUS   8'h14
`define MC2_CMD_SCAN2X   8'h15
`define MC2_CMD_DL_START 8'h20
`define MC2_CMD_DL_DATA  8'h21
`define MC2_CMD_DL_END   8'h22

// ROM download address width
`define MC2_ADDR_W 22

// clk_sys cycles from reset release to the OSD menu request
`define MC2_POWER_ON_CYCLES 256

// game sound comes in as two's complement
`define MC2_SIGNED_SND 1

`endif

// File: src/mc2_pkg.sv
// shared types of the platform base

package mc2_pkg;

`include "mc2_consts.svh"

    // channel widths: base game video, board DAC, scan-doubler output
    localparam int BASE_W  = 4;
    localparam int OUT_W   = 5;
    localparam int SCAN2X_W = 6;

    typedef logic [BASE_W-1:0]   rgb4_t;
    typedef logic [OUT_W-1:0]    rgb5_t;
    typedef logic [SCAN2X_W-1:0] rgb6_t;

    // first byte of every SPI frame from the I/O controller
    typedef enum logic [7:0] {
        CMD_STATUS   = `MC2_CMD_STATUS,
        CMD_SCAN2X   = `MC2_CMD_SCAN2X,
        CMD_DL_START = `MC2_CMD_DL_START,
        CMD_DL_DATA  = `MC2_CMD_DL_DATA,
        CMD_DL_END   = `MC2_CMD_DL_END
    } spi_cmd_e;

    // byte returned to the controller while the command shifts in
    // menu asks it to open the OSD, loading keeps it closed
    typedef enum logic [7:0] {
        OSD_MENU    = 8'h3f,
        OSD_LOADING = 8'hff
    } osd_state_e;

endpackage

// File: src/spi_rom_loader.sv
// SPI frame decoder and ROM download

`include "mc2_consts.svh"

module spi_rom_loader (
    input  logic                   clk_sys,
    input  logic                   rst,
    input  logic                   spi_sck,
    input  logic                   spi_di,
    input  logic                   spi_ss2,
    output logic                   spi_do,
    input  mc2_pkg::osd_state_e    osd_state,
    output logic                   cfg_wr,
    output logic [2:0]             cfg_sel,
    output logic [7:0]             cfg_data,
    output logic                   downloading,
    output logic [`MC2_ADDR_W-1:0] ioctl_addr,
    output logic [7:0]             ioctl_data,
    output logic                   ioctl_req,
    input  logic                   ioctl_ack,
    output logic                   overrun
);

    // write handshake phases
    typedef enum logic [1:0] {
        WR_IDLE,
        WR_REQ,
        WR_DONE
    } wr_state_e;

    // [0] meta, [1] synced, [2] history for edge detect
    logic [2:0] sck_sync;
    logic [1:0] di_sync;
    logic [1:0] ss_sync;
    logic       sck_rise;
    logic       sck_fall;
    logic       frame_act;

    logic [6:0]              shreg;
    logic [2:0]              bit_cnt;
    logic [2:0]              byte_idx;
    logic [7:0]              byte_in;
    logic [7:0]              out_sh;
    mc2_pkg::spi_cmd_e       cmd;
    wr_state_e               wr_state;
    logic [`MC2_ADDR_W-1:0]  addr_next;

    logic       byte_done;
    logic       cfg_hit;
    logic [2:0] cfg_sel_nxt;
    logic       wr_hit;
    logic       wr_free;
    logic       wr_take;

    always_ff @(posedge clk_sys or posedge rst)
    begin
        if (rst)
        begin
            sck_sync <= '0;
            di_sync  <= '0;
            // select idles high
            ss_sync  <= '1;
        end
        else
        begin
            sck_sync <= {sck_sync[1:0], spi_sck};
            di_sync  <= {di_sync[0], spi_di};
            ss_sync  <= {ss_sync[0], spi_ss2};
        end
    end

    assign sck_rise  = sck_sync[1] & ~sck_sync[2];
    assign sck_fall  = ~sck_sync[1] & sck_sync[2];
    assign frame_act = ~ss_sync[1];
    assign spi_do    = out_sh[7];

    always_comb
    begin
        byte_in   = {shreg, di_sync[1]};
        byte_done = frame_act & sck_rise & (bit_cnt == 3'd7);
        // status lanes follow the command byte from the low lane up
        cfg_hit   = byte_done & (byte_idx != 3'd0) &
                    (((cmd == mc2_pkg::CMD_STATUS) & (byte_idx <= 3'd4)) |
                     ((cmd == mc2_pkg::CMD_SCAN2X) & (byte_idx == 3'd1)));
        cfg_sel_nxt = (cmd == mc2_pkg::CMD_SCAN2X) ? 3'd4 : byte_idx - 3'd1;
        wr_hit    = byte_done & (byte_idx != 3'd0) & (cmd == mc2_pkg::CMD_DL_DATA);
        // slot frees as soon as ack drops
        wr_free   = (wr_state == WR_IDLE) | ((wr_state == WR_DONE) & ~ioctl_ack);
        wr_take   = wr_hit & wr_free;
    end

    always_ff @(posedge clk_sys or posedge rst)
    begin
        if (rst)
        begin
            bit_cnt     <= '0;
            byte_idx    <= '0;
            cmd         <= mc2_pkg::CMD_STATUS;
            out_sh      <= '0;
            cfg_wr      <= 1'b0;
            downloading <= 1'b0;
            addr_next   <= '0;
            overrun     <= 1'b0;
            wr_state    <= WR_IDLE;
            ioctl_req   <= 1'b0;
        end
        else
        begin
            cfg_wr <= cfg_hit;
            // frame position, cleared between frames
            if (!frame_act)
            begin
                bit_cnt  <= '0;
                byte_idx <= '0;
                out_sh   <= osd_state;
            end
            else
            begin
                if (sck_fall)
                    out_sh <= {out_sh[6:0], 1'b0};
                if (sck_rise)
                begin
                    bit_cnt <= bit_cnt + 3'd1;
                    // index saturates, data frames run long
                    if (bit_cnt == 3'd7 && byte_idx != 3'd7)
                        byte_idx <= byte_idx + 3'd1;
                end
            end
            // command byte
            if (byte_done && byte_idx == 3'd0)
            begin
                cmd <= mc2_pkg::spi_cmd_e'(byte_in);
                if (byte_in == `MC2_CMD_DL_START)
                begin
                    downloading <= 1'b1;
                    addr_next   <= '0;
                end
                else if (byte_in == `MC2_CMD_DL_END)
                    downloading <= 1'b0;
            end
            if (wr_hit && !wr_free)
                overrun <= 1'b1;
            // four-phase handshake
            case (wr_state)
                WR_REQ:
                begin
                    if (ioctl_ack)
                    begin
                        ioctl_req <= 1'b0;
                        wr_state  <= WR_DONE;
                    end
                end
                WR_DONE:
                begin
                    if (!ioctl_ack)
                        wr_state <= WR_IDLE;
                end
                default:
                begin
                end
            endcase
            if (wr_take)
            begin
                ioctl_req <= 1'b1;
                wr_state  <= WR_REQ;
                addr_next <= addr_next + 1'b1;
            end
        end
    end

    // payload registers
    always_ff @(posedge clk_sys)
    begin
        if (frame_act && sck_rise)
            shreg <= byte_in[6:0];
        if (cfg_hit)
        begin
            cfg_sel  <= cfg_sel_nxt;
            cfg_data <= byte_in;
        end
        if (wr_take)
        begin
            ioctl_addr <= addr_next;
            ioctl_data <= byte_in;
        end
    end

    // memory side samples address and data any time while req is up
    a_req_payload_stable: assert property (@(posedge clk_sys) disable iff (rst)
        ioctl_req && $past(ioctl_req) |-> $stable(ioctl_addr) && $stable(ioctl_data));

endmodule

// File: src/core_cfg_regs.sv
// core configuration registers

`include "mc2_consts.svh"

module core_cfg_regs (
    input  logic                clk_sys,
    input  logic                rst,
    input  logic                cfg_wr,
    input  logic [2:0]          cfg_sel,
    input  logic [7:0]          cfg_data,
    input  logic                downloading,
    output logic [31:0]         status,
    output logic                scan2x_enb,
    output mc2_pkg::osd_state_e osd_state,
    output logic                osd_shown
);

    localparam int PWR_W = $clog2(`MC2_POWER_ON_CYCLES + 1);

    logic [PWR_W-1:0] pwr_cnt;
    logic             pwr_done;

    assign pwr_done = (pwr_cnt == '0);

    // byte lanes 0..3 of status, lane 4 is the scan-doubler disable bit
    always_ff @(posedge clk_sys or posedge rst)
    begin
        if (rst)
        begin
            status     <= '0;
            scan2x_enb <= 1'b0;
        end
        else if (cfg_wr)
        begin
            if (cfg_sel == 3'd4)
                scan2x_enb <= cfg_data[0];
            else if (cfg_sel < 3'd4)
                status[8*cfg_sel[1:0] +: 8] <= cfg_data;
        end
    end

    // power-on delay before the menu is requested
    always_ff @(posedge clk_sys or posedge rst)
    begin
        if (rst)
            pwr_cnt <= PWR_W'(`MC2_POWER_ON_CYCLES);
        else if (!pwr_done)
            pwr_cnt <= pwr_cnt - 1'b1;
    end

    // menu until the first download after the delay, then loading for good
    always_ff @(posedge clk_sys or posedge rst)
    begin
        if (rst)
            osd_state <= mc2_pkg::OSD_MENU;
        else if (pwr_done && downloading)
            osd_state <= mc2_pkg::OSD_LOADING;
    end

    assign osd_shown = pwr_done && (osd_state == mc2_pkg::OSD_MENU);

    // loading is sticky, only a reset brings the menu back
    a_osd_sticky: assert property (@(posedge clk_sys) disable iff (rst)
        osd_state == mc2_pkg::OSD_LOADING |=> osd_state == mc2_pkg::OSD_LOADING);

endmodule

// File: src/video_out_mux.sv
// video output select and sync

module video_out_mux (
    input  logic           clk_sys,
    input  logic           rst,
    input  logic           scan2x_enb,
    input  mc2_pkg::rgb4_t game_r,
    input  mc2_pkg::rgb4_t game_g,
    input  mc2_pkg::rgb4_t game_b,
    input  logic           hs,
    input  logic           vs,
    input  mc2_pkg::rgb6_t scan2x_r,
    input  mc2_pkg::rgb6_t scan2x_g,
    input  mc2_pkg::rgb6_t scan2x_b,
    input  logic           scan2x_hs,
    input  logic           scan2x_vs,
    output mc2_pkg::rgb5_t video_r,
    output mc2_pkg::rgb5_t video_g,
    output mc2_pkg::rgb5_t video_b,
    output logic           video_hs,
    output logic           video_vs
);

    // one channel for the DAC
    // base repeats its MSB into the spare bit, scan-doubled drops its LSB
    function automatic mc2_pkg::rgb5_t pick_chan(
        input logic           base,
        input mc2_pkg::rgb4_t game,
        input mc2_pkg::rgb6_t dbl
    );
        if (base)
            return {game, game[3]};
        return dbl[5:1];
    endfunction

    logic csync;

    // composite sync for a SCART cable
    assign csync = ~((~hs) ^ (~vs));

    always_ff @(posedge clk_sys or posedge rst)
    begin
        if (rst)
        begin
            video_r  <= '0;
            video_g  <= '0;
            video_b  <= '0;
            video_hs <= 1'b0;
            video_vs <= 1'b0;
        end
        else
        begin
            video_r  <= pick_chan(scan2x_enb, game_r, scan2x_r);
            video_g  <= pick_chan(scan2x_enb, game_g, scan2x_g);
            video_b  <= pick_chan(scan2x_enb, game_b, scan2x_b);
            // vs held high switches the TV into RGB mode
            video_hs <= scan2x_enb ? csync : scan2x_hs;
            video_vs <= scan2x_enb ? 1'b1 : scan2x_vs;
        end
    end

endmodule

// File: src/sd_audio_dac.sv
// one-bit sigma-delta sound DAC

`include "mc2_consts.svh"

module sd_audio_dac (
    input  logic        clk_sys,
    input  logic        rst,
    input  logic [15:0] snd,
    output logic        snd_pwm
);

    logic [15:0] snd_u;
    logic [15:0] acc;
    logic [16:0] sum;

    // signed sound to offset binary by flipping the sign bit
    assign snd_u = {snd[15] ^ 1'(`MC2_SIGNED_SND), snd[14:0]};

    // carry out of the accumulator is the pulse density
    assign sum = {1'b0, acc} + {1'b0, snd_u};

    always_ff @(posedge clk_sys or posedge rst)
    begin
        if (rst)
        begin
            acc     <= '0;
            snd_pwm <= 1'b0;
        end
        else
        begin
            acc     <= sum[15:0];
            snd_pwm <= sum[16];
        end
    end

endmodule

// File: src/mc2_base.sv
// arcade platform base top

`include "mc2_consts.svh"

module mc2_base (
    input  logic                   clk_sys,
    input  logic                   rst,
    // SPI from the I/O controller
    input  logic                   spi_sck,
    input  logic                   spi_di,
    input  logic                   spi_ss2,
    output logic                   spi_do,
    // ROM download
    output logic [`MC2_ADDR_W-1:0] ioctl_addr,
    output logic [7:0]             ioctl_data,
    output logic                   ioctl_req,
    input  logic                   ioctl_ack,
    output logic                   downloading,
    output logic                   overrun,
    // configuration
    output logic [31:0]            status,
    output logic                   scan2x_enb,
    output logic                   osd_shown,
    // base video
    input  mc2_pkg::rgb4_t         game_r,
    input  mc2_pkg::rgb4_t         game_g,
    input  mc2_pkg::rgb4_t         game_b,
    input  logic                   hs,
    input  logic                   vs,
    // scan-doubled video
    input  mc2_pkg::rgb6_t         scan2x_r,
    input  mc2_pkg::rgb6_t         scan2x_g,
    input  mc2_pkg::rgb6_t         scan2x_b,
    input  logic                   scan2x_hs,
    input  logic                   scan2x_vs,
    // board video DAC
    output mc2_pkg::rgb5_t         video_r,
    output mc2_pkg::rgb5_t         video_g,
    output mc2_pkg::rgb5_t         video_b,
    output logic                   video_hs,
    output logic                   video_vs,
    // sound
    input  logic [15:0]            snd,
    output logic                   snd_pwm
);

    // loader to config block
    logic                cfg_wr;
    logic [2:0]          cfg_sel;
    logic [7:0]          cfg_data;
    mc2_pkg::osd_state_e osd_state;

    spi_rom_loader i_loader (
        .clk_sys     (clk_sys),
        .rst         (rst),
        .spi_sck     (spi_sck),
        .spi_di      (spi_di),
        .spi_ss2     (spi_ss2),
        .spi_do      (spi_do),
        .osd_state   (osd_state),
        .cfg_wr      (cfg_wr),
        .cfg_sel     (cfg_sel),
        .cfg_data    (cfg_data),
        .downloading (downloading),
        .ioctl_addr  (ioctl_addr),
        .ioctl_data  (ioctl_data),
        .ioctl_req   (ioctl_req),
        .ioctl_ack   (ioctl_ack),
        .overrun     (overrun)
    );

    core_cfg_regs i_cfg (
        .clk_sys     (clk_sys),
        .rst         (rst),
        .cfg_wr      (cfg_wr),
        .cfg_sel     (cfg_sel),
        .cfg_data    (cfg_data),
        .downloading (downloading),
        .status      (status),
        .scan2x_enb  (scan2x_enb),
        .osd_state   (osd_state),
        .osd_shown   (osd_shown)
    );

    video_out_mux i_video (
        .clk_sys    (clk_sys),
        .rst        (rst),
        .scan2x_enb (scan2x_enb),
        .game_r     (game_r),
        .game_g     (game_g),
        .game_b     (game_b),
        .hs         (hs),
        .vs         (vs),
        .scan2x_r   (scan2x_r),
        .scan2x_g   (scan2x_g),
        .scan2x_b   (scan2x_b),
        .scan2x_hs  (scan2x_hs),
        .scan2x_vs  (scan2x_vs),
        .video_r    (video_r),
        .video_g    (video_g),
        .video_b    (video_b),
        .video_hs   (video_hs),
        .video_vs   (video_vs)
    );

    sd_audio_dac i_dac (
        .clk_sys (clk_sys),
        .rst     (rst),
        .snd     (snd),
        .snd_pwm (snd_pwm)
    );

endmodule

// File: testbench/tb_mc2_base.sv
// testbench for the platform base

`include "mc2_consts.svh"

module tb_mc2_base;

    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [31:0] SEED = 32'he45b;
    localparam int N_STATUS = 4;
    localparam int N_SCAN   = 2;
    localparam int N_ROM    = 40;
    localparam int N_VIDEO  = 200;
    localparam int N_SND    = 8;
    localparam int SND_HOLD = 300;
    // command and payload bytes of all frames, two extra scan-doubler frames for video
    localparam int SPI_BYTES = N_STATUS * 5 + (N_SCAN + 2) * 2 + 1 + (N_ROM + 1) + 1;
    localparam int WATCHDOG_CYCLES = SPI_BYTES * 8 * 16 + 2 * (N_VIDEO + 1)
                                     + N_SND * SND_HOLD + 2000;

    logic                   clk_sys;
    logic                   rst;
    logic                   spi_sck;
    logic                   spi_di;
    logic                   spi_ss2;
    logic                   spi_do;
    logic [`MC2_ADDR_W-1:0] ioctl_addr;
    logic [7:0]             ioctl_data;
    logic                   ioctl_req;
    logic                   ioctl_ack;
    logic                   downloading;
    logic                   overrun;
    logic [31:0]            status;
    logic                   scan2x_enb;
    logic                   osd_shown;
    mc2_pkg::rgb4_t         game_r;
    mc2_pkg::rgb4_t         game_g;
    mc2_pkg::rgb4_t         game_b;
    logic                   hs;
    logic                   vs;
    mc2_pkg::rgb6_t         scan2x_r;
    mc2_pkg::rgb6_t         scan2x_g;
    mc2_pkg::rgb6_t         scan2x_b;
    logic                   scan2x_hs;
    logic                   scan2x_vs;
    mc2_pkg::rgb5_t         video_r;
    mc2_pkg::rgb5_t         video_g;
    mc2_pkg::rgb5_t         video_b;
    logic                   video_hs;
    logic                   video_vs;
    logic [15:0]            snd;
    logic                   snd_pwm;

    // error counts per kind of check
    int err_rgb;
    int err_bit;
    int err_word;
    int err_rom;
    int err_osd;
    int err_other;

    // stimulus and handshake random streams
    logic [31:0] rng;
    logic [31:0] rng_ack;

    // reference state
    logic [31:0]            status_m;
    logic                   scan2x_m;
    mc2_pkg::osd_state_e    osd_m;
    logic [`MC2_ADDR_W-1:0] rom_addr_m;
    logic [7:0]             rom_q[$];
    int                     hs_count;

    // latency check on the last bit of a config byte: 0 none, 1 status, 2 scan2x
    int          lat_kind;
    logic [31:0] lat_old_word;
    logic [31:0] lat_new_word;
    logic        lat_old_bit;
    logic        lat_new_bit;

    mc2_base i_dut (
        .clk_sys     (clk_sys),
        .rst         (rst),
        .spi_sck     (spi_sck),
        .spi_di      (spi_di),
        .spi_ss2     (spi_ss2),
        .spi_do      (spi_do),
        .ioctl_addr  (ioctl_addr),
        .ioctl_data  (ioctl_data),
        .ioctl_req   (ioctl_req),
        .ioctl_ack   (ioctl_ack),
        .downloading (downloading),
        .overrun     (overrun),
        .status      (status),
        .scan2x_enb  (scan2x_enb),
        .osd_shown   (osd_shown),
        .game_r      (game_r),
        .game_g      (game_g),
        .game_b      (game_b),
        .hs          (hs),
        .vs          (vs),
        .scan2x_r    (scan2x_r),
        .scan2x_g    (scan2x_g),
        .scan2x_b    (scan2x_b),
        .scan2x_hs   (scan2x_hs),
        .scan2x_vs   (scan2x_vs),
        .video_r     (video_r),
        .video_g     (video_g),
        .video_b     (video_b),
        .video_hs    (video_hs),
        .video_vs    (video_vs),
        .snd         (snd),
        .snd_pwm     (snd_pwm)
    );

    initial
    begin
        clk_sys = 1'b0;
        forever #5 clk_sys = ~clk_sys;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic check_rgb5(input string name, input mc2_pkg::rgb5_t act,
                              input mc2_pkg::rgb5_t exp);
        if (act !== exp)
        begin
            err_rgb++;
            $display("error at %0t: %s expected %h, actual %h", $time, name, exp, act);
        end
    endtask

    task automatic check_bit(input string name, input logic act, input logic exp);
        if (act !== exp)
        begin
            err_bit++;
            $display("error at %0t: %s expected %b, actual %b", $time, name, exp, act);
        end
    endtask

    task automatic check_word32(input string name, input logic [31:0] act,
                                input logic [31:0] exp);
        if (act !== exp)
        begin
            err_word++;
            $display("error at %0t: %s expected %h, actual %h", $time, name, exp, act);
        end
    endtask

    task automatic check_rom_write(input logic [`MC2_ADDR_W-1:0] act_addr,
                                   input logic [7:0] act_data,
                                   input logic [`MC2_ADDR_W-1:0] exp_addr,
                                   input logic [7:0] exp_data);
        if (act_addr !== exp_addr)
        begin
            err_rom++;
            $display("error at %0t: ioctl_addr expected %h, actual %h",
                     $time, exp_addr, act_addr);
        end
        if (act_data !== exp_data)
        begin
            err_rom++;
            $display("error at %0t: ioctl_data expected %h, actual %h",
                     $time, exp_data, act_data);
        end
    endtask

    task automatic check_osd(input string name, input mc2_pkg::osd_state_e act,
                             input mc2_pkg::osd_state_e exp);
        if (act !== exp)
        begin
            err_osd++;
            $display("error at %0t: %s expected %h, actual %h", $time, name, exp, act);
        end
    endtask

    // one byte each way, 8 clk_sys per sck half period, sck idles low
    task automatic spi_byte(input logic [7:0] tx, output logic [7:0] rx);
        int i;
        int k;
        for (i = 7; i >= 0; i--)
        begin
            @(posedge clk_sys);
            spi_sck <= 1'b0;
            spi_di  <= tx[i];
            repeat (7) @(posedge clk_sys);
            // spi_do settled long after the falling edge
            @(negedge clk_sys);
            rx[i] = spi_do;
            @(posedge clk_sys);
            spi_sck <= 1'b1;
            for (k = 1; k < 8; k++)
            begin
                @(posedge clk_sys);
                if (i == 0 && lat_kind != 0)
                begin
                    @(negedge clk_sys);
                    // new value exactly 4 cycles after the last rising sck
                    if (lat_kind == 1)
                        check_word32("status", status, (k < 4) ? lat_old_word : lat_new_word);
                    else
                        check_bit("scan2x_enb", scan2x_enb, (k < 4) ? lat_old_bit : lat_new_bit);
                end
            end
        end
    endtask

    task automatic frame_begin();
        @(posedge clk_sys);
        spi_ss2 <= 1'b0;
        repeat (8) @(posedge clk_sys);
    endtask

    task automatic frame_end();
        @(posedge clk_sys);
        spi_sck <= 1'b0;
        repeat (7) @(posedge clk_sys);
        @(posedge clk_sys);
        spi_ss2 <= 1'b1;
        repeat (16) @(posedge clk_sys);
    endtask

    // command byte, returns the OSD byte shifted back
    task automatic send_cmd(input logic [7:0] cmd);
        logic [7:0] rx;
        // osd_shown as the command byte starts, a download start drops it mid-byte
        check_bit("osd_shown", osd_shown, osd_m == mc2_pkg::OSD_MENU);
        spi_byte(cmd, rx);
        check_osd("spi_do osd byte", mc2_pkg::osd_state_e'(rx), osd_m);
    endtask

    task automatic write_status(input logic [31:0] val);
        logic [7:0] rx;
        int b;
        frame_begin();
        send_cmd(`MC2_CMD_STATUS);
        // low lane first
        for (b = 0; b < 4; b++)
        begin
            lat_old_word = status_m;
            status_m[8*b +: 8] = val[8*b +: 8];
            lat_new_word = status_m;
            lat_kind = 1;
            spi_byte(val[8*b +: 8], rx);
            lat_kind = 0;
        end
        frame_end();
    endtask

    task automatic write_scan2x(input logic val);
        logic [7:0] rx;
        frame_begin();
        send_cmd(`MC2_CMD_SCAN2X);
        rng = xorshift32(rng);
        lat_old_bit = scan2x_m;
        lat_new_bit = val;
        scan2x_m = val;
        lat_kind = 2;
        // upper bits are don't care
        spi_byte({rng[7:1], val}, rx);
        lat_kind = 0;
        frame_end();
    endtask

    task automatic rom_download();
        logic [7:0] rx;
        int i;
        frame_begin();
        send_cmd(`MC2_CMD_DL_START);
        frame_end();
        rom_addr_m = '0;
        osd_m = mc2_pkg::OSD_LOADING;
        @(negedge clk_sys);
        check_bit("downloading", downloading, 1'b1);
        check_osd("osd_state", i_dut.osd_state, mc2_pkg::OSD_LOADING);
        check_bit("osd_shown", osd_shown, 1'b0);
        frame_begin();
        send_cmd(`MC2_CMD_DL_DATA);
        for (i = 0; i < N_ROM; i++)
        begin
            rng = xorshift32(rng);
            rom_q.push_back(rng[7:0]);
            spi_byte(rng[7:0], rx);
        end
        frame_end();
        @(negedge clk_sys);
        check_bit("downloading", downloading, 1'b1);
        frame_begin();
        send_cmd(`MC2_CMD_DL_END);
        frame_end();
        @(negedge clk_sys);
        check_bit("downloading", downloading, 1'b0);
        check_bit("overrun", overrun, 1'b0);
        if (hs_count != N_ROM || rom_q.size() != 0)
        begin
            err_other++;
            $display("ROM download finished with %0d of %0d writes acknowledged",
                     hs_count, N_ROM);
        end
    endtask

    // random video each cycle, outputs checked one cycle later
    task automatic run_video(input logic base, input int cycles);
        mc2_pkg::rgb5_t er;
        mc2_pkg::rgb5_t eg;
        mc2_pkg::rgb5_t eb;
        logic           ehs;
        logic           evs;
        int             n;
        for (n = 0; n <= cycles; n++)
        begin
            @(posedge clk_sys);
            rng = xorshift32(rng);
            game_r   <= rng[3:0];
            game_g   <= rng[7:4];
            game_b   <= rng[11:8];
            hs       <= rng[12];
            vs       <= rng[13];
            scan2x_r <= rng[19:14];
            scan2x_g <= rng[25:20];
            scan2x_b <= rng[31:26];
            rng = xorshift32(rng);
            scan2x_hs <= rng[0];
            scan2x_vs <= rng[1];
            @(negedge clk_sys);
            if (n > 0)
            begin
                check_rgb5("video_r", video_r, er);
                check_rgb5("video_g", video_g, eg);
                check_rgb5("video_b", video_b, eb);
                check_bit("video_hs", video_hs, ehs);
                check_bit("video_vs", video_vs, evs);
            end
            if (base)
            begin
                // msb repeated into the fifth bit, vs high for SCART
                er  = {game_r, game_r[3]};
                eg  = {game_g, game_g[3]};
                eb  = {game_b, game_b[3]};
                // csync high while both syncs agree
                ehs = (hs == vs);
                evs = 1'b1;
            end
            else
            begin
                er  = scan2x_r[5:1];
                eg  = scan2x_g[5:1];
                eb  = scan2x_b[5:1];
                ehs = scan2x_hs;
                evs = scan2x_vs;
            end
        end
    endtask

    // memory side of the ROM write handshake
    initial
    begin : ack_responder
        logic [7:0]  exp_d;
        int unsigned dly;
        ioctl_ack = 1'b0;
        forever
        begin
            @(negedge clk_sys);
            if (ioctl_req)
            begin
                if (rom_q.size() == 0)
                begin
                    err_other++;
                    $display("ROM write request at %0t with no byte sent", $time);
                end
                else
                begin
                    exp_d = rom_q.pop_front();
                    check_rom_write(ioctl_addr, ioctl_data, rom_addr_m, exp_d);
                    rom_addr_m++;
                end
                rng_ack = xorshift32(rng_ack);
                dly = rng_ack % 13;
                repeat (dly) @(posedge clk_sys);
                @(posedge clk_sys);
                ioctl_ack <= 1'b1;
                do
                    @(negedge clk_sys);
                while (ioctl_req);
                @(posedge clk_sys);
                ioctl_ack <= 1'b0;
                hs_count++;
            end
        end
    end

    // offset-binary accumulator, carry out one cycle later
    initial
    begin : sound_model
        logic [16:0] sum;
        logic [15:0] acc_m;
        logic        pwm_m;
        acc_m = '0;
        pwm_m = 1'b0;
        forever
        begin
            @(negedge clk_sys);
            if (!rst)
            begin
                check_bit("snd_pwm", snd_pwm, pwm_m);
                sum = {1'b0, acc_m} + {1'b0, snd ^ (`MC2_SIGNED_SND ? 16'h8000 : 16'h0000)};
                acc_m = sum[15:0];
                pwm_m = sum[16];
            end
        end
    end

    initial
    begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clk_sys);
        $display("run timed out after %0d cycles", WATCHDOG_CYCLES);
        $display("Simulation failed");
        $finish;
    end

    initial
    begin : main
        int i;
        rst       = 1'b1;
        spi_sck   = 1'b0;
        spi_di    = 1'b0;
        spi_ss2   = 1'b1;
        game_r    = '0;
        game_g    = '0;
        game_b    = '0;
        hs        = 1'b0;
        vs        = 1'b0;
        scan2x_r  = '0;
        scan2x_g  = '0;
        scan2x_b  = '0;
        scan2x_hs = 1'b0;
        scan2x_vs = 1'b0;
        snd       = '0;
        err_rgb   = 0;
        err_bit   = 0;
        err_word  = 0;
        err_rom   = 0;
        err_osd   = 0;
        err_other = 0;
        rng       = SEED;
        rng_ack   = {SEED[15:0], SEED[31:16]};
        status_m  = '0;
        scan2x_m  = 1'b0;
        osd_m     = mc2_pkg::OSD_MENU;
        hs_count  = 0;
        lat_kind  = 0;
        repeat (10) @(posedge clk_sys);
        rst <= 1'b0;
        // menu hidden during the power-on delay
        repeat (20) @(posedge clk_sys);
        @(negedge clk_sys);
        check_bit("osd_shown", osd_shown, 1'b0);
        check_word32("status", status, 32'h0);
        check_bit("scan2x_enb", scan2x_enb, 1'b0);
        repeat (`MC2_POWER_ON_CYCLES) @(posedge clk_sys);
        @(negedge clk_sys);
        check_bit("osd_shown", osd_shown, 1'b1);
        check_osd("osd_state", i_dut.osd_state, mc2_pkg::OSD_MENU);
        for (i = 0; i < N_STATUS; i++)
        begin
            rng = xorshift32(rng);
            write_status(rng);
        end
        for (i = 0; i < N_SCAN; i++)
        begin
            rng = xorshift32(rng);
            write_scan2x(rng[0]);
        end
        rom_download();
        // base mode, then scan-doubled
        write_scan2x(1'b1);
        run_video(1'b1, N_VIDEO);
        write_scan2x(1'b0);
        run_video(1'b0, N_VIDEO);
        for (i = 0; i < N_SND; i++)
        begin
            @(posedge clk_sys);
            rng = xorshift32(rng);
            snd <= rng[15:0];
            repeat (SND_HOLD - 1) @(posedge clk_sys);
        end
        @(negedge clk_sys);
        check_bit("overrun", overrun, 1'b0);
        check_word32("status", status, status_m);
        $display("errors: rgb5 %0d, bit %0d, word32 %0d, rom %0d, osd %0d, other %0d",
                 err_rgb, err_bit, err_word, err_rom, err_osd, err_other);
        if (err_rgb + err_bit + err_word + err_rom + err_osd + err_other == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

// File: mc2_base.f
+incdir+src
src/mc2_pkg.sv
src/spi_rom_loader.sv
src/core_cfg_regs.sv
src/video_out_mux.sv
src/sd_audio_dac.sv
src/mc2_base.sv
testbench/tb_mc2_base.sv
